/* hw/video_config.svh */
// Screen geometry and layer count for the video output stage.
// Include wherever the counters, the layer loop or the palette depth are sized.

`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Tile layers stacked in front of the backdrop
// At most 4, the colour code holds a 2-bit layer index
`define NUM_LAYERS 3

// Horizontal timing in pixels
`define H_ACTIVE 64
`define H_TOTAL 80

// Vertical timing in lines
`define V_ACTIVE 16
`define V_TOTAL 20

// Palette RAM address width, two bytes per colour code
`define PAL_ADDR_W 8

`endif

/* hw/video_pkg.sv */
// Shared types for the video output stage.
// Modules pull these in with a wildcard import in their header.

`include "video_config.svh"

package video_pkg;

    // Beam position
    typedef logic [7:0] hpos_t;
    typedef logic [7:0] vpos_t;

    // Layer index in bits 6:5, tile pattern in bits 4:0
    typedef logic [6:0] pxl_code_t;

    // Palette byte address
    typedef logic [`PAL_ADDR_W-1:0] pal_addr_t;

    // Full CPU address, bit 8 selects the scroll registers
    typedef logic [8:0] cpu_addr_t;

    typedef logic [7:0] byte_t;

    // Blue over green over red
    typedef logic [14:0] rgb_t;
    typedef logic [4:0] col5_t;

    // Which palette byte the mixer is reading this clk
    typedef enum logic {
        fetch_low,
        fetch_high
    } phase_t;

endpackage

/* hw/video_bus_if.sv */
// Beam position and pixel strobe shared by the timing generator,
// the tile layers, the priority stage and the colour mixer.

`timescale 1ns/1ps

interface video_bus_if import video_pkg::*; ();

    // High one clk in two
    logic  pxl_cen;
    // Active-low blanking levels
    logic  lhbl;
    logic  lvbl;
    // Beam counters, valid across a whole pixel period
    hpos_t h;
    vpos_t v;

    modport source (
        output pxl_cen, lhbl, lvbl, h, v
    );

    modport sink (
        input pxl_cen, lhbl, lvbl, h, v
    );

endinterface

/* hw/video_timing.sv */
// Video timing generator.
// Divides clk by two for the pixel strobe and runs the beam counters
// and blanking levels that drive the rest of the display pipeline.

`timescale 1ns/1ps
`include "video_config.svh"

module video_timing import video_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    video_bus_if.source vb,
    output logic        pxl_cen_out
);

    logic  cen;
    hpos_t h_cnt;
    vpos_t v_cnt;
    logic  h_last;
    logic  v_last;

    // Toggle divider
    // Low in the first clk after reset, so the first strobe is on the second
    always_ff @(posedge clk) begin
        if (rst) begin
            cen <= 1'b0;
        end else begin
            cen <= ~cen;
        end
    end

    // End of line and end of frame
    assign h_last = (h_cnt == hpos_t'(`H_TOTAL - 1));
    assign v_last = (v_cnt == vpos_t'(`V_TOTAL - 1));

    // Beam counters step only on the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (cen) begin
            if (h_last) begin
                h_cnt <= '0;
                // Next line, wrap at the bottom of the frame
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + vpos_t'(1);
                end
            end else begin
                h_cnt <= h_cnt + hpos_t'(1);
            end
        end
    end

    // Shared bus
    assign vb.pxl_cen = cen;
    assign vb.h       = h_cnt;
    assign vb.v       = v_cnt;

    // Blanking is low outside the visible window
    assign vb.lhbl = (h_cnt < hpos_t'(`H_ACTIVE));
    assign vb.lvbl = (v_cnt < vpos_t'(`V_ACTIVE));

    // Strobe copy for the top-level pin
    assign pxl_cen_out = cen;

endmodule

/* hw/tile_layer.sv */
// One horizontally scrolled tile layer.
// Turns the beam position and its own scroll register into a 7-bit
// colour code, one pixel period behind the beam.

`timescale 1ns/1ps

module tile_layer import video_pkg::*; #(
    parameter int LAYER_ID = 0
) (
    input  logic      clk,
    input  logic      rst,
    video_bus_if.sink vb,
    input  logic      scroll_we,
    input  byte_t     scroll_din,
    output pxl_code_t code,
    output logic      opaque
);

    byte_t        scroll_q;
    hpos_t        h_scr;
    logic [4:0]   tile_pat;
    logic [1:0]   layer_idx;

    // CPU scroll register
    // Picked up by the code register at the next strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            scroll_q <= '0;
        end else if (scroll_we) begin
            scroll_q <= scroll_din;
        end
    end

    // Scrolled column, 8-bit add wraps modulo 256
    assign h_scr = vb.h + scroll_q;

    // Tile column mixed with the line number gives the pattern
    assign tile_pat = h_scr[7:3] ^ vb.v[4:0];

    assign layer_idx = 2'(LAYER_ID);

    // Code and transparency registered once per pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            code   <= '0;
            opaque <= 1'b0;
        end else if (vb.pxl_cen) begin
            code   <= {layer_idx, tile_pat};
            // Pattern values with low bits 00 are see-through
            opaque <= |tile_pat[1:0];
        end
    end

endmodule

/* hw/layer_priority.sv */
// Layer priority stage.
// Layer 0 is in front. The first opaque layer code wins, otherwise the
// backdrop code 0 is sent on to the colour mixer.

`timescale 1ns/1ps
`include "video_config.svh"

module layer_priority import video_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    video_bus_if.sink              vb,
    input  pxl_code_t              codes [`NUM_LAYERS],
    input  logic [`NUM_LAYERS-1:0] opaque,
    output pxl_code_t              sel_code
);

    pxl_code_t pick;

    // Scan from the back so the lowest opaque index overwrites the rest
    always_comb begin
        pick = '0;
        for (int i = `NUM_LAYERS - 1; i >= 0; i--) begin
            if (opaque[i]) begin
                pick = codes[i];
            end
        end
    end

    // One pixel period through this stage
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_code <= '0;
        end else if (vb.pxl_cen) begin
            sel_code <= pick;
        end
    end

endmodule

/* hw/palette_colmix.sv */
// Colour mixer with CPU palette.
// Looks each pixel code up as two bytes in a 256-byte RAM, assembles the
// 15-bit colour and delays blanking to match. Blanked pixels come out black.

`timescale 1ns/1ps
`include "video_config.svh"

module palette_colmix import video_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    video_bus_if.sink vb,
    input  pxl_code_t sel_code,
    input  pal_addr_t cpu_addr,
    input  byte_t     cpu_dout,
    input  logic      pal_we,
    input  logic      pal_rd,
    output byte_t     pal_dout,
    output col5_t     red,
    output col5_t     green,
    output col5_t     blue,
    output logic      lhbl_dly,
    output logic      lvbl_dly
);

    byte_t     pal_ram [2**`PAL_ADDR_W];
    phase_t    phase;
    pal_addr_t fetch_addr;
    byte_t     fetch_byte;
    byte_t     low_byte;
    rgb_t      col_q;
    logic [2:0] hbl_sr;
    logic [2:0] vbl_sr;
    logic      show;

    // CPU port
    // Writes land at the next clk, reads return one clk after the strobe
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[cpu_addr] <= cpu_dout;
        end
        if (pal_rd) begin
            pal_dout <= pal_ram[cpu_addr];
        end
    end

    // Fetch phase follows the strobe
    // Low byte in the clk before the strobe, high byte on the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= fetch_low;
        end else if (vb.pxl_cen) begin
            phase <= fetch_low;
        end else begin
            phase <= fetch_high;
        end
    end

    // Pixel port, two bytes per code
    assign fetch_addr = {sel_code, phase == fetch_high};
    assign fetch_byte = pal_ram[fetch_addr];

    // Hold the low byte until the high one arrives
    always_ff @(posedge clk) begin
        if (phase == fetch_low) begin
            low_byte <= fetch_byte;
        end
    end

    // Blanking pipeline, three pixel periods
    // Stage 1 lines up with the code being coloured now
    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
        end else if (vb.pxl_cen) begin
            hbl_sr <= {hbl_sr[1:0], vb.lhbl};
            vbl_sr <= {vbl_sr[1:0], vb.lvbl};
        end
    end

    assign show = hbl_sr[1] & vbl_sr[1];

    // Colour register, black outside the visible window
    // Top bit of the high byte is unused
    always_ff @(posedge clk) begin
        if (rst) begin
            col_q <= '0;
        end else if (vb.pxl_cen) begin
            if (show) begin
                col_q <= {fetch_byte[6:0], low_byte};
            end else begin
                col_q <= '0;
            end
        end
    end

    assign {blue, green, red} = col_q;
    assign lhbl_dly = hbl_sr[2];
    assign lvbl_dly = vbl_sr[2];

endmodule

/* hw/video_top.sv */
// Top level of the video output stage.
// Decodes the 9-bit CPU address into palette and scroll strobes and chains
// timing, tile layers, priority and colour mixer. Three pixel periods of latency.

`timescale 1ns/1ps
`include "video_config.svh"

module video_top import video_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_addr_t cpu_addr,
    input  byte_t     cpu_dout,
    input  logic      cpu_we,
    input  logic      cpu_rd,
    output byte_t     pal_dout,
    output col5_t     red,
    output col5_t     green,
    output col5_t     blue,
    output logic      lhbl_dly,
    output logic      lvbl_dly,
    output logic      pxl_cen
);

    logic                   pal_sel;
    logic                   pal_we;
    logic                   pal_rd;
    logic [`NUM_LAYERS-1:0] scroll_we;
    pxl_code_t              layer_code [`NUM_LAYERS];
    logic [`NUM_LAYERS-1:0] layer_opaque;
    pxl_code_t              sel_code;

    video_bus_if vb ();

    // Lower half of the map is palette, upper half the scroll registers
    assign pal_sel = ~cpu_addr[8];
    assign pal_we  = cpu_we & pal_sel;
    assign pal_rd  = cpu_rd & pal_sel;

    video_timing video_timing_inst (
        .clk         (clk),
        .rst         (rst),
        .vb          (vb.source),
        .pxl_cen_out (pxl_cen)
    );

    // One layer per scroll address 0x100 + k
    for (genvar k = 0; k < `NUM_LAYERS; k++) begin : g_layer
        assign scroll_we[k] = cpu_we & cpu_addr[8] & (cpu_addr[7:0] == 8'(k));

        tile_layer #(
            .LAYER_ID (k)
        ) tile_layer_inst (
            .clk        (clk),
            .rst        (rst),
            .vb         (vb.sink),
            .scroll_we  (scroll_we[k]),
            .scroll_din (cpu_dout),
            .code       (layer_code[k]),
            .opaque     (layer_opaque[k])
        );
    end

    layer_priority layer_priority_inst (
        .clk      (clk),
        .rst      (rst),
        .vb       (vb.sink),
        .codes    (layer_code),
        .opaque   (layer_opaque),
        .sel_code (sel_code)
    );

    palette_colmix palette_colmix_inst (
        .clk      (clk),
        .rst      (rst),
        .vb       (vb.sink),
        .sel_code (sel_code),
        .cpu_addr (pal_addr_t'(cpu_addr[`PAL_ADDR_W-1:0])),
        .cpu_dout (cpu_dout),
        .pal_we   (pal_we),
        .pal_rd   (pal_rd),
        .pal_dout (pal_dout),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

/* tb/tb_video_top.sv */
// Testbench for the video output stage.
// Fills the palette, checks readback, then compares whole frames against a
// reference model with zero and random scroll, plus blanking behaviour.

`timescale 1ns/1ps
`include "video_config.svh"

module tb_video_top;

    localparam int WATCHDOG_CYCLES = 12 * `H_TOTAL * `V_TOTAL * 2;

    logic       clk;
    logic       rst;
    logic [8:0] cpu_addr;
    logic [7:0] cpu_dout;
    logic       cpu_we;
    logic       cpu_rd;
    logic [7:0] pal_dout;
    logic [4:0] red;
    logic [4:0] green;
    logic [4:0] blue;
    logic       lhbl_dly;
    logic       lvbl_dly;
    logic       pxl_cen;

    // Reference copies of the CPU-written state
    logic [7:0]  pal_ref [256];
    logic [7:0]  scroll_ref [`NUM_LAYERS];
    logic [31:0] rnd_state = 32'ha4d56383;

    // Monitor state
    int   err_cnt = 0;
    int   check_cnt = 0;
    int   frame_cnt = 0;
    int   check_frame = -1;
    int   lines_checked = 0;
    int   hx = 0;
    int   vx = 0;
    int   line_len = 0;
    int   line_cnt = 0;
    logic prev_lhbl = 1'b0;
    logic prev_lvbl = 1'b0;
    logic pix_chk = 1'b0;
    logic blank_chk = 1'b0;
    int   errs_before;

    video_top video_top_inst (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_we   (cpu_we),
        .cpu_rd   (cpu_rd),
        .pal_dout (pal_dout),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .pxl_cen  (pxl_cen)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected colour for beam position (hx, vx)
    function automatic logic [14:0] ref_pixel(input int hp, input int vp);
        logic [7:0] hs;
        logic [4:0] t;
        logic [6:0] c;
        logic       found;
        c = '0;
        found = 1'b0;
        // Lowest-numbered opaque layer wins
        for (int k = 0; k < `NUM_LAYERS; k++) begin
            hs = 8'(hp + int'(scroll_ref[k]));
            t = hs[7:3] ^ 5'(vp);
            if (!found && t[1:0] != 2'b00) begin
                c = {2'(k), t};
                found = 1'b1;
            end
        end
        // High byte bits 6:0 above the low byte
        return {pal_ref[{c, 1'b1}][6:0], pal_ref[{c, 1'b0}]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic cpu_write(input logic [8:0] addr, input logic [7:0] data);
        @(posedge clk);
        #10;
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = 1'b1;
        @(posedge clk);
        #10;
        cpu_we = 1'b0;
    endtask

    // Data is back one clk after the read strobe
    task automatic cpu_read_check(input logic [8:0] addr, input logic [7:0] expected);
        @(posedge clk);
        #10;
        cpu_addr = addr;
        cpu_rd   = 1'b1;
        @(posedge clk);
        #10;
        cpu_rd = 1'b0;
        check_value("pal_dout", 32'(pal_dout), 32'(expected));
    endtask

    task automatic wait_frame_done(input int target);
        while (frame_cnt <= target) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_at_start);
        if (err_cnt == errs_at_start) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, err_cnt - errs_at_start);
        end
    endtask

    // Compare process
    // Samples mid pixel period where outputs are stable
    always @(negedge clk) begin
        if (rst) begin
            prev_lhbl = 1'b0;
            prev_lvbl = 1'b0;
        end else if (pxl_cen) begin
            if (lvbl_dly && !prev_lvbl) begin
                frame_cnt++;
                line_cnt = 0;
            end
            if (lhbl_dly && !prev_lhbl) begin
                hx = 0;
                line_len = 0;
                vx = (lvbl_dly && !prev_lvbl) ? 0 : vx + 1;
                if (lvbl_dly) begin
                    line_cnt++;
                end
            end else if (lhbl_dly) begin
                hx++;
            end
            if (lhbl_dly) begin
                line_len++;
            end
            if (frame_cnt == check_frame) begin
                if (lhbl_dly && lvbl_dly) begin
                    if (pix_chk) begin
                        check_value("rgb", 32'({blue, green, red}), 32'(ref_pixel(hx, vx)));
                    end
                end else if (blank_chk) begin
                    check_value("rgb in blanking", 32'({blue, green, red}), 32'h0);
                end
                // Line and frame lengths at the falling edges
                if (blank_chk && !lhbl_dly && prev_lhbl) begin
                    check_value("lhbl_dly pixels", 32'(line_len), 32'(`H_ACTIVE));
                    lines_checked++;
                end
                if (blank_chk && !lvbl_dly && prev_lvbl) begin
                    check_value("lvbl_dly lines", 32'(line_cnt), 32'(`V_ACTIVE));
                end
            end
            prev_lhbl = lhbl_dly;
            prev_lvbl = lvbl_dly;
        end
    end

    // Watchdog, twelve frames
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the display pipeline did not finish the frames in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_we   = 1'b0;
        cpu_rd   = 1'b0;
        for (int k = 0; k < `NUM_LAYERS; k++) begin
            scroll_ref[k] = '0;
        end
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;

        // Test 1, outputs quiet before the first pixel leaves the pipeline
        // Strobe low in the first clk after reset, high in the second
        errs_before = err_cnt;
        for (int i = 0; i < 2; i++) begin
            check_value("pxl_cen", 32'(pxl_cen), 32'(i));
            check_value("lhbl_dly", 32'(lhbl_dly), 32'h0);
            check_value("lvbl_dly", 32'(lvbl_dly), 32'h0);
            check_value("rgb", 32'({blue, green, red}), 32'h0);
            @(posedge clk);
            #10;
        end
        report_test(1, "reset state", errs_before);

        // Test 2, random palette then readback
        errs_before = err_cnt;
        for (int a = 0; a < 256; a++) begin
            rnd_state = lcg_next(rnd_state);
            pal_ref[a] = rnd_state[23:16];
            cpu_write(9'(a), pal_ref[a]);
        end
        for (int a = 0; a < 256; a++) begin
            cpu_read_check(9'(a), pal_ref[a]);
        end
        report_test(2, "palette readback", errs_before);

        // Test 3, one full frame with all scrolls at zero
        errs_before = err_cnt;
        pix_chk = 1'b1;
        check_frame = frame_cnt + 1;
        wait_frame_done(check_frame);
        report_test(3, "zero scroll frame", errs_before);

        // Test 4, random scroll, skip a frame so the writes settle
        errs_before = err_cnt;
        check_frame = -1;
        for (int k = 0; k < `NUM_LAYERS; k++) begin
            rnd_state = lcg_next(rnd_state);
            scroll_ref[k] = rnd_state[23:16];
            cpu_write(9'h100 + 9'(k), scroll_ref[k]);
        end
        check_frame = frame_cnt + 2;
        wait_frame_done(check_frame);
        report_test(4, "random scroll frame", errs_before);

        // Test 5, black during blanking and blank lengths
        errs_before = err_cnt;
        pix_chk = 1'b0;
        blank_chk = 1'b1;
        lines_checked = 0;
        check_frame = frame_cnt + 1;
        wait_frame_done(check_frame);
        check_value("lines measured", 32'(lines_checked), 32'(`V_TOTAL));
        report_test(5, "blanking", errs_before);

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/video_pkg.sv
hw/video_bus_if.sv
hw/video_timing.sv
hw/tile_layer.sv
hw/layer_priority.sv
hw/palette_colmix.sv
hw/video_top.sv
tb/tb_video_top.sv

/* Makefile */
# Verilator build and run for the video output stage

SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_video_top
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) hw/video_config.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
